/* include/extended_hamming.svh */
// Macros deriving parity and data widths from an extended Hamming block width
`ifndef EXTENDED_HAMMING_SVH
`define EXTENDED_HAMMING_SVH

// Inner Hamming parity bits plus the extra parity bit
// Width 8 gives 4, width 13 gives 5, width 16 gives 5
`define GET_EXTENDED_HAMMING_PARITY_WIDTH_FROM_BLOCK_WIDTH(width) \
  ($clog2((width)) + 1)

// Everything that is not parity carries data
`define GET_EXTENDED_HAMMING_DATA_WIDTH_FROM_BLOCK_WIDTH(width) \
  ((width) - `GET_EXTENDED_HAMMING_PARITY_WIDTH_FROM_BLOCK_WIDTH(width))

`endif

/* verilog/ecc_mem_pkg.sv */
// Widths, data/block/address/counter types, host op enum, request, response, access, status
package ecc_mem_pkg;

// User data bits per word
localparam int data_width = 8;
// 12-bit Hamming code above the extra parity at bit 0
localparam int block_width = 13;
localparam int addr_width = 4;
localparam int mem_depth = 16;
// Error counters saturate at all ones
localparam int count_width = 8;

typedef logic [data_width-1:0] data_t;
typedef logic [block_width-1:0] block_t;
typedef logic [addr_width-1:0] addr_t;
typedef logic [count_width-1:0] count_t;

// Code 3 is unused
typedef enum logic [1:0] {
  op_read,
  op_write,
  op_write_raw
} host_op_e;

// Raw block only matters for op_write_raw
typedef struct packed {
  host_op_e op;
  addr_t    addr;
  data_t    data;
  block_t   raw_block;
} host_req_t;

// Valid during the response strobe only
typedef struct packed {
  data_t data;
  logic  correctable_error;
  logic  uncorrectable_error;
} host_resp_t;

// One RAM access from either peer
typedef struct packed {
  logic   enable;
  logic   write;
  addr_t  addr;
  block_t block;
} mem_access_t;

typedef struct packed {
  count_t corrected_count;
  count_t uncorrectable_count;
  logic   pass_complete;
} scrub_status_t;

endpackage

/* verilog/extended_hamming_block_encoder.sv */
// Extended Hamming block encoder for one data word
`timescale 1ns/1ps
`include "extended_hamming.svh"

module extended_hamming_block_encoder (
  input  ecc_mem_pkg::data_t  data,
  output ecc_mem_pkg::block_t block
);

import ecc_mem_pkg::*;

localparam int data_count = `GET_EXTENDED_HAMMING_DATA_WIDTH_FROM_BLOCK_WIDTH(block_width);
// Inner code parity only, bit 0 is handled apart
localparam int parity_count =
  `GET_EXTENDED_HAMMING_PARITY_WIDTH_FROM_BLOCK_WIDTH(block_width) - 1;

// Bit n sits at Hamming position n
block_t positioned;

always_comb begin : build_block
  int   data_index;
  logic parity;
  positioned = '0;
  data_index = 0;
  // Data fills the positions that are not powers of two
  // Lowest data bit goes to position 3
  for (int pos = 1; pos < block_width; pos++) begin
    if ((pos & (pos - 1)) != 0 && data_index < data_count) begin
      positioned[pos] = data[data_index];
      data_index++;
    end
  end
  // Parity bit at 2**p covers all positions with bit p set
  for (int p = 0; p < parity_count; p++) begin
    parity = 1'b0;
    for (int pos = 1; pos < block_width; pos++) begin
      if (((pos >> p) & 1) != 0) begin
        parity = parity ^ positioned[pos];
      end
    end
    positioned[1 << p] = parity;
  end
  // Extra parity makes the whole block even
  positioned[0] = ^positioned[block_width-1:1];
end

assign block = positioned;

endmodule

/* verilog/hamming_block_corrector.sv */
// Plain Hamming block syndrome and single-bit correction
`timescale 1ns/1ps
`include "extended_hamming.svh"

module hamming_block_corrector #(
  parameter int block_width = 12
) (
  input  logic [block_width-1:0] block,
  output logic                   error,
  output logic [block_width-1:0] corrected_block
);

// Plain block is an extended block minus its extra parity bit
localparam int syndrome_width =
  `GET_EXTENDED_HAMMING_PARITY_WIDTH_FROM_BLOCK_WIDTH(block_width + 1) - 1;

logic [syndrome_width-1:0] syndrome;

// Bit i sits at Hamming position i+1
// XOR of the positions of all set bits
always_comb begin
  syndrome = '0;
  for (int i = 0; i < block_width; i++) begin
    if (block[i]) begin
      syndrome = syndrome ^ syndrome_width'(i + 1);
    end
  end
end

// Any failing parity check
assign error = (syndrome != '0);

// Flip the bit the syndrome points at
// Syndromes past the last position flip nothing
always_comb begin
  corrected_block = block;
  for (int i = 0; i < block_width; i++) begin
    if (syndrome == syndrome_width'(i + 1)) begin
      corrected_block[i] = ~block[i];
    end
  end
end

endmodule

/* verilog/extended_hamming_block_corrector.sv */
// Extended Hamming corrector with single-bit repair and double-bit detection
`timescale 1ns/1ps

module extended_hamming_block_corrector #(
  parameter int block_width = 13
) (
  input  logic [block_width-1:0] block,
  output logic [block_width-1:0] corrected_block,
  output logic                   correctable_error,
  output logic                   uncorrectable_error
);

logic [block_width-2:0] hamming_block;
logic [block_width-2:0] corrected_hamming_block;
logic                   extra_parity;
logic                   expected_extra_parity;
logic                   extra_parity_error;
logic                   hamming_error;

// Inner Hamming block sits above the extra parity
assign hamming_block = block[block_width-1:1];
assign extra_parity  = block[0];

// Even parity of the inner block as received
assign expected_extra_parity = ^hamming_block;
assign extra_parity_error    = extra_parity ^ expected_extra_parity;

hamming_block_corrector #(
  .block_width     ( block_width - 1         )
) hamming_corrector (
  .block           ( hamming_block           ),
  .error           ( hamming_error           ),
  .corrected_block ( corrected_hamming_block )
);

// Odd overall parity means one flipped bit
assign correctable_error = extra_parity_error;

// Bad syndrome under even overall parity means two flipped bits
assign uncorrectable_error = hamming_error && !extra_parity_error;

// Repairing the inner block inverts its parity
assign corrected_block = {corrected_hamming_block, expected_extra_parity ^ hamming_error};

endmodule

/* verilog/ecc_block_ram.sv */
// 16-entry block array with synchronous write and read from the registered access
`timescale 1ns/1ps

module ecc_block_ram (
  input  logic                     clock,
  input  ecc_mem_pkg::mem_access_t access,
  output ecc_mem_pkg::block_t      read_block
);

import ecc_mem_pkg::*;

// Contents undefined until written
block_t memory [mem_depth];

// Write lands at the end of the forwarded cycle
always_ff @(posedge clock) begin
  if (access.enable && access.write) begin
    memory[access.addr] <= access.block;
  end
end

// Arbiter output register acts as the read address register
// so a peer sees its block one cycle after presenting the read
assign read_block = memory[access.addr];

endmodule

/* verilog/ecc_mem_arbiter.sv */
// Fixed-priority host over scrubber selection with registered RAM access and grant
`timescale 1ns/1ps

module ecc_mem_arbiter (
  input  logic                     clock,
  input  logic                     rst_n,
  input  ecc_mem_pkg::mem_access_t host_access,
  input  ecc_mem_pkg::mem_access_t scrub_access,
  output logic                     scrub_grant,
  output ecc_mem_pkg::mem_access_t ram_access
);

import ecc_mem_pkg::*;

mem_access_t selected_access;

// Host always wins and is never refused
// Idle cycles forward a cleared access
always_comb begin
  if (host_access.enable) begin
    selected_access = host_access;
  end else if (scrub_access.enable) begin
    selected_access = scrub_access;
  end else begin
    selected_access = '0;
  end
end

// Grant lines up with the forwarded access
// High means ram_access this cycle belongs to the scrubber
always_ff @(posedge clock) begin
  if (!rst_n) begin
    ram_access  <= '0;
    scrub_grant <= 1'b0;
  end else begin
    ram_access  <= selected_access;
    scrub_grant <= !host_access.enable && scrub_access.enable;
  end
end

endmodule

/* verilog/ecc_host_port.sv */
// Host request to RAM access conversion with write encoding and corrected read response
`timescale 1ns/1ps

module ecc_host_port (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     host_req_strobe,
  input  ecc_mem_pkg::host_req_t   host_req,
  output logic                     host_ready,
  output logic                     host_resp_strobe,
  output ecc_mem_pkg::host_resp_t  host_resp,
  output ecc_mem_pkg::mem_access_t host_access,
  input  ecc_mem_pkg::block_t      read_block
);

import ecc_mem_pkg::*;

block_t encoded_block;
block_t corrected_block;
logic   correctable_error;
logic   uncorrectable_error;
// Read forwarded to the RAM this cycle
logic   read_in_flight;

extended_hamming_block_encoder encoder (
  .data  ( host_req.data ),
  .block ( encoded_block )
);

extended_hamming_block_corrector #(
  .block_width         ( block_width         )
) corrector (
  .block               ( read_block          ),
  .corrected_block     ( corrected_block     ),
  .correctable_error   ( correctable_error   ),
  .uncorrectable_error ( uncorrectable_error )
);

// Raw writes bypass the encoder for fault injection
// Unused op code behaves as a read
always_comb begin
  host_access.enable = host_req_strobe;
  host_access.write  = (host_req.op == op_write) || (host_req.op == op_write_raw);
  host_access.addr   = host_req.addr;
  host_access.block  = (host_req.op == op_write_raw) ? host_req.raw_block : encoded_block;
end

// Strobe cycle 0, RAM read cycle 1, response cycle 2
always_ff @(posedge clock) begin
  if (!rst_n) begin
    read_in_flight   <= 1'b0;
    host_resp_strobe <= 1'b0;
  end else begin
    read_in_flight   <= host_req_strobe && !host_access.write;
    host_resp_strobe <= read_in_flight;
  end
end

// Data sits at positions 3, 5 to 7 and 9 to 12
always_ff @(posedge clock) begin
  if (read_in_flight) begin
    host_resp.data                <= {corrected_block[12:9], corrected_block[7:5],
                                      corrected_block[3]};
    host_resp.correctable_error   <= correctable_error;
    host_resp.uncorrectable_error <= uncorrectable_error;
  end
end

// Busy only while the single outstanding read is at the RAM
assign host_ready = !read_in_flight;

endmodule

/* verilog/ecc_scrubber.sv */
// Background scrub FSM with write-back of corrected blocks and saturating error counters
`timescale 1ns/1ps

module ecc_scrubber (
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic                       scrub_enable,
  output ecc_mem_pkg::mem_access_t   scrub_access,
  input  logic                       scrub_grant,
  input  ecc_mem_pkg::mem_access_t   ram_access,
  input  ecc_mem_pkg::block_t        read_block,
  output ecc_mem_pkg::scrub_status_t scrub_status
);

import ecc_mem_pkg::*;

typedef enum logic [2:0] {
  s_idle,
  s_read,
  s_check,
  s_write_back,
  s_next,
  s_done
} scrub_state_e;

scrub_state_e state;
addr_t        scrub_addr;
block_t       repaired_block;
block_t       corrected_block;
logic         correctable_error;
logic         uncorrectable_error;
logic         block_correctable;
logic         block_uncorrectable;
logic         hazard_seen;
logic         host_write_hit;

extended_hamming_block_corrector #(
  .block_width         ( block_width         )
) corrector (
  .block               ( read_block          ),
  .corrected_block     ( corrected_block     ),
  .correctable_error   ( correctable_error   ),
  .uncorrectable_error ( uncorrectable_error )
);

// Forwarded host write to the block under repair
// Without grant the forwarded access is never ours
assign host_write_hit = ram_access.enable && ram_access.write &&
                        (ram_access.addr == scrub_addr) && !scrub_grant;

// Request held until the grant shows it was taken
// Write-back withdrawn once the host has overwritten the block
always_comb begin
  scrub_access.write = (state == s_write_back);
  scrub_access.addr  = scrub_addr;
  scrub_access.block = repaired_block;
  case (state)
    s_read:       scrub_access.enable = !scrub_grant;
    s_write_back: scrub_access.enable = !scrub_grant && !hazard_seen && !host_write_hit;
    default:      scrub_access.enable = 1'b0;
  endcase
end

always_ff @(posedge clock) begin
  if (!rst_n) begin
    state               <= s_idle;
    scrub_addr          <= '0;
    block_correctable   <= 1'b0;
    block_uncorrectable <= 1'b0;
    hazard_seen         <= 1'b0;
    scrub_status        <= '0;
  end else begin
    case (state)
      // New pass restarts counts at address 0
      s_idle: begin
        if (scrub_enable) begin
          state        <= s_read;
          scrub_addr   <= '0;
          scrub_status <= '0;
        end
      end
      // Block is on read_block in the grant cycle
      s_read: begin
        if (scrub_grant) begin
          state               <= s_check;
          block_correctable   <= correctable_error;
          block_uncorrectable <= uncorrectable_error;
          hazard_seen         <= 1'b0;
        end
      end
      // Count the error even if the write-back is dropped later
      s_check: begin
        if (block_correctable && scrub_status.corrected_count != '1) begin
          scrub_status.corrected_count <= scrub_status.corrected_count + 1'b1;
        end
        if (block_uncorrectable && scrub_status.uncorrectable_count != '1) begin
          scrub_status.uncorrectable_count <= scrub_status.uncorrectable_count + 1'b1;
        end
        hazard_seen <= host_write_hit;
        state       <= block_correctable ? s_write_back : s_next;
      end
      s_write_back: begin
        if (scrub_grant || hazard_seen || host_write_hit) begin
          state <= s_next;
        end
      end
      // Stop between addresses when disabled
      s_next: begin
        if (!scrub_enable) begin
          state <= s_idle;
        end else if (scrub_addr == addr_t'(mem_depth - 1)) begin
          state                      <= s_done;
          scrub_status.pass_complete <= 1'b1;
        end else begin
          scrub_addr <= scrub_addr + 1'b1;
          state      <= s_read;
        end
      end
      // Pass-complete holds until enable falls
      s_done: begin
        if (!scrub_enable) begin
          state                      <= s_idle;
          scrub_status.pass_complete <= 1'b0;
        end
      end
      default: state <= s_idle;
    endcase
  end
end

// Repaired block captured with the flags
always_ff @(posedge clock) begin
  if (state == s_read && scrub_grant) begin
    repaired_block <= corrected_block;
  end
end

endmodule

/* verilog/ecc_memory_top.sv */
// SECDED memory top with host port, scrubber, arbiter and block RAM
`timescale 1ns/1ps

module ecc_memory_top (
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic                       host_req_strobe,
  input  ecc_mem_pkg::host_req_t     host_req,
  output logic                       host_ready,
  output logic                       host_resp_strobe,
  output ecc_mem_pkg::host_resp_t    host_resp,
  input  logic                       scrub_enable,
  output ecc_mem_pkg::scrub_status_t scrub_status
);

import ecc_mem_pkg::*;

mem_access_t host_access;
mem_access_t scrub_access;
// Registered access seen by the RAM and the scrubber
mem_access_t ram_access;
logic        scrub_grant;
// Shared by both correctors
block_t      read_block;

ecc_host_port host_port (
  .clock            ( clock            ),
  .rst_n            ( rst_n            ),
  .host_req_strobe  ( host_req_strobe  ),
  .host_req         ( host_req         ),
  .host_ready       ( host_ready       ),
  .host_resp_strobe ( host_resp_strobe ),
  .host_resp        ( host_resp        ),
  .host_access      ( host_access      ),
  .read_block       ( read_block       )
);

ecc_scrubber scrubber (
  .clock        ( clock        ),
  .rst_n        ( rst_n        ),
  .scrub_enable ( scrub_enable ),
  .scrub_access ( scrub_access ),
  .scrub_grant  ( scrub_grant  ),
  .ram_access   ( ram_access   ),
  .read_block   ( read_block   ),
  .scrub_status ( scrub_status )
);

ecc_mem_arbiter arbiter (
  .clock        ( clock        ),
  .rst_n        ( rst_n        ),
  .host_access  ( host_access  ),
  .scrub_access ( scrub_access ),
  .scrub_grant  ( scrub_grant  ),
  .ram_access   ( ram_access   )
);

ecc_block_ram block_ram (
  .clock      ( clock      ),
  .access     ( ram_access ),
  .read_block ( read_block )
);

endmodule

/* tb/ecc_memory_tb.sv */
// Testbench for the SECDED memory: file-driven host operations, fault reads and scrub checks
`timescale 1ns/1ps

module ecc_memory_tb;

import ecc_mem_pkg::*;

// Wait limits in clock cycles
localparam int ready_timeout = 20;
localparam int resp_timeout  = 10;
localparam int scrub_timeout = 2000;

logic          clock;
logic          rst_n;
logic          host_req_strobe;
host_req_t     host_req;
logic          host_ready;
logic          host_resp_strobe;
host_resp_t    host_resp;
logic          scrub_enable;
scrub_status_t scrub_status;

// Stimulus file fields
int               fd;
int               fields;
int               op_count;
int               gap;
int unsigned      seed_result;
// Long enough for the widest comment line
logic [8*160-1:0] line;
logic [3:0]       op;
logic [3:0]       addr;
logic [15:0]      value;
logic [7:0]       exp_data;
logic [7:0]       exp_ce;
logic [7:0]       exp_ue;

ecc_memory_top dut (
  .clock            ( clock            ),
  .rst_n            ( rst_n            ),
  .host_req_strobe  ( host_req_strobe  ),
  .host_req         ( host_req         ),
  .host_ready       ( host_ready       ),
  .host_resp_strobe ( host_resp_strobe ),
  .host_resp        ( host_resp        ),
  .scrub_enable     ( scrub_enable     ),
  .scrub_status     ( scrub_status     )
);

// 40 ns period
initial begin
  clock = 1'b0;
  forever #20 clock = ~clock;
end

task automatic stop_on_error(input string what);
  $display("%s", what);
  $display("Verification failed");
  $fatal(1, "Run stopped at the first error");
endtask

task automatic check_value(input string name, input logic [15:0] actual,
                           input logic [15:0] expected);
  if (actual !== expected) begin
    stop_on_error($sformatf("MISMATCH %s actual 0x%0h expected 0x%0h", name, actual, expected));
  end
endtask

task automatic wait_host_ready();
  int cycles;
  cycles = 0;
  while (host_ready !== 1'b1) begin
    if (cycles == ready_timeout) begin
      stop_on_error("host_ready stayed low too long before a request");
    end else begin
      @(negedge clock);
      cycles++;
    end
  end
endtask

// One-cycle strobe, returns one falling edge after the strobe cycle
task automatic send_request(input host_op_e req_op, input addr_t req_addr,
                            input data_t req_data, input block_t req_block);
  wait_host_ready();
  host_req.op        = req_op;
  host_req.addr      = req_addr;
  host_req.data      = req_data;
  host_req.raw_block = req_block;
  host_req_strobe    = 1'b1;
  @(negedge clock);
  host_req_strobe = 1'b0;
endtask

// Response due exactly 2 cycles after the strobe cycle
task automatic read_and_check(input addr_t req_addr, input data_t expected_data,
                              input logic [7:0] expected_ce, input logic [7:0] expected_ue,
                              input logic check_data);
  int cycles;
  send_request(op_read, req_addr, '0, '0);
  check_value("host_ready", host_ready, 1'b0);
  cycles = 1;
  while (host_resp_strobe !== 1'b1) begin
    if (cycles == resp_timeout) begin
      stop_on_error("host_resp_strobe never came after a read");
    end else begin
      @(negedge clock);
      cycles++;
    end
  end
  check_value("host_resp_strobe latency", cycles, 2);
  check_value("host_ready", host_ready, 1'b1);
  // Data after a double-bit error means nothing
  if (check_data) begin
    check_value("host_resp.data", host_resp.data, expected_data);
  end
  check_value("host_resp.correctable_error", host_resp.correctable_error, expected_ce);
  check_value("host_resp.uncorrectable_error", host_resp.uncorrectable_error, expected_ue);
endtask

task automatic wait_scrub_pass(input count_t expected_corrected,
                               input count_t expected_uncorrectable);
  int cycles;
  cycles = 0;
  while (scrub_status.pass_complete !== 1'b1) begin
    if (cycles == scrub_timeout) begin
      stop_on_error("Scrub pass did not complete");
    end else begin
      @(negedge clock);
      cycles++;
    end
  end
  check_value("scrub_status.corrected_count", scrub_status.corrected_count,
              expected_corrected);
  check_value("scrub_status.uncorrectable_count", scrub_status.uncorrectable_count,
              expected_uncorrectable);
endtask

// Pass-complete must drop once enable falls
task automatic stop_scrub();
  int cycles;
  scrub_enable = 1'b0;
  cycles = 0;
  while (scrub_status.pass_complete !== 1'b0) begin
    if (cycles == scrub_timeout) begin
      stop_on_error("pass_complete stayed high after scrub_enable fell");
    end else begin
      @(negedge clock);
      cycles++;
    end
  end
endtask

// Op codes as listed at the top of the stimulus file
task automatic run_operation();
  case (op)
    4'h0: read_and_check(addr, exp_data, exp_ce, exp_ue, 1'b1);
    4'h1: send_request(op_write, addr, value[7:0], '0);
    4'h2: send_request(op_write_raw, addr, '0, value[12:0]);
    4'h3: read_and_check(addr, exp_data, exp_ce, exp_ue, 1'b0);
    4'h4: scrub_enable = 1'b1;
    4'h5: wait_scrub_pass(exp_ce, exp_ue);
    4'h6: stop_scrub();
    default: stop_on_error($sformatf("Unknown op %0h in the stimulus file", op));
  endcase
endtask

initial begin
  rst_n           = 1'b0;
  host_req_strobe = 1'b0;
  host_req        = '0;
  scrub_enable    = 1'b0;
  op_count        = 0;
  // Fixed seed for the idle gaps
  seed_result = $urandom(63643);
  repeat (16) @(negedge clock);
  rst_n = 1'b1;
  @(negedge clock);
  // Idle state right after reset
  check_value("host_resp_strobe", host_resp_strobe, 1'b0);
  check_value("host_ready", host_ready, 1'b1);
  check_value("scrub_status.corrected_count", scrub_status.corrected_count, 0);
  check_value("scrub_status.uncorrectable_count", scrub_status.uncorrectable_count, 0);
  check_value("scrub_status.pass_complete", scrub_status.pass_complete, 1'b0);
  fd = $fopen("tb/ecc_memory_stim.txt", "r");
  if (fd == 0) begin
    stop_on_error("Cannot open tb/ecc_memory_stim.txt");
  end
  while (!$feof(fd)) begin
    line = '0;
    fields = $fgets(line, fd);
    // Comment and blank lines do not parse
    fields = $sscanf(line, "%h %h %h %h %h %h", op, addr, value, exp_data, exp_ce, exp_ue);
    if (fields == 6) begin
      run_operation();
      op_count++;
      gap = $urandom_range(3, 0);
      repeat (gap) @(negedge clock);
    end
  end
  $fclose(fd);
  if (op_count == 0) begin
    stop_on_error("Stimulus file held no operations");
  end else begin
    $display("Verification passed");
    $finish;
  end
end

endmodule

/* tb/ecc_memory_stim.txt */
# op addr value exp_data exp_ce exp_ue, hex; op 0 read, 1 write, 2 raw write, 3 read flags only
# op 4 scrub on, 5 wait for scrub pass with exp_ce and exp_ue as counts, 6 scrub off
1 0 0000 00 0 0
0 0 0000 00 0 0
1 1 00ff 00 0 0
0 1 0000 ff 0 0
1 2 0012 00 0 0
1 3 00c3 00 0 0
0 2 0000 12 0 0
0 3 0000 c3 0 0
1 a 0081 00 0 0
1 b 007e 00 0 0
1 c 0034 00 0 0
1 d 00e1 00 0 0
1 e 005d 00 0 0
1 f 002b 00 0 0
0 f 0000 2b 0 0
0 c 0000 34 0 0
# Single flips: a5 bit 0, 3c bit 3, 96 bit 8, 5a bit 12
2 4 144f 00 0 0
2 5 06cd 00 0 0
2 6 1374 00 0 0
2 7 1aa0 00 0 0
# Double flips: 0f bits 2 and 9, f0 bits 0 and 6
2 8 02fb 00 0 0
2 9 1e50 00 0 0
0 4 0000 a5 1 0
0 5 0000 3c 1 0
0 6 0000 96 1 0
0 7 0000 5a 1 0
3 8 0000 00 0 1
3 9 0000 00 0 1
4 0 0000 00 0 0
1 c 0077 00 0 0
0 c 0000 77 0 0
0 1 0000 ff 0 0
0 e 0000 5d 0 0
5 0 0000 00 4 2
0 4 0000 a5 0 0
0 5 0000 3c 0 0
0 6 0000 96 0 0
0 7 0000 5a 0 0
3 8 0000 00 0 1
3 9 0000 00 0 1
0 c 0000 77 0 0
6 0 0000 00 0 0

/* verilog.f */
+incdir+include
verilog/ecc_mem_pkg.sv
verilog/extended_hamming_block_encoder.sv
verilog/hamming_block_corrector.sv
verilog/extended_hamming_block_corrector.sv
verilog/ecc_block_ram.sv
verilog/ecc_mem_arbiter.sv
verilog/ecc_host_port.sv
verilog/ecc_scrubber.sv
verilog/ecc_memory_top.sv
tb/ecc_memory_tb.sv
